/* common/wb_pkg.sv */
package wb_pkg;

    // datapath
    localparam int XLEN = 32;
    localparam int REG_AW = 5;
    localparam int BE_W = XLEN / 8;

    // data cache geometry, one word per line
    localparam int DC_LINES = 16;
    localparam int DC_IDX_W = 4;
    localparam int DC_TAG_W = 26;

    // extra cycles a miss costs over a hit
    localparam int DC_MISS_CYCLES = 3;
    localparam int DC_CNT_W = 2;

    // word-addressed backing store
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW = 8;

    // memory-stage opcodes, encodings are fixed
    typedef enum logic [3:0] {
        OP_ALU   = 4'd0,
        OP_LD_B  = 4'd1,
        OP_LD_BU = 4'd2,
        OP_LD_H  = 4'd3,
        OP_LD_HU = 4'd4,
        OP_LD_W  = 4'd5,
        // load-linked, sets the LL bit
        OP_LL    = 4'd6,
        OP_ST_B  = 4'd7,
        OP_ST_H  = 4'd8,
        OP_ST_W  = 4'd9,
        // store-conditional, stores only with the LL bit set
        OP_SC    = 4'd10
    } wb_op_e;

    // data cache load sequencer
    typedef enum logic [1:0] {
        DC_IDLE   = 2'd0,
        DC_LOOKUP = 2'd1,
        DC_FILL   = 2'd2,
        DC_DONE   = 2'd3
    } dc_state_e;

endpackage

/* hdl/llbit_reg.sv */
`timescale 1ns/10ps

module llbit_reg (
    input  logic clk,
    input  logic rst_i,
    input  logic we_i,
    input  logic value_i,
    output logic ll_bit_o
);

    logic ll_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ll_q <= 1'b0;
        end else if (we_i) begin
            ll_q <= value_i;
        end
    end

    // a write in flight is already visible to the next instruction
    assign ll_bit_o = we_i ? value_i : ll_q;

    ll_clear_after_reset_a: assert property (
        @(posedge clk) rst_i |=> !ll_q
    ) else $error("LL bit not cleared by reset");

endmodule

/* dcache/dcache_lite.sv */
`timescale 1ns/10ps

module dcache_lite (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     req_i,
    input  logic                     we_i,
    input  logic [wb_pkg::BE_W-1:0]  be_i,
    input  logic [wb_pkg::XLEN-1:0]  addr_i,
    input  logic [wb_pkg::XLEN-1:0]  wdata_i,
    input  logic                     commit_i,
    output logic                     data_ok_o,
    output logic [wb_pkg::XLEN-1:0]  rdata_o
);

    import wb_pkg::*;

    logic [DC_LINES-1:0] valid_q;
    logic [DC_TAG_W-1:0] tag_q [DC_LINES];
    logic [XLEN-1:0]     data_q [DC_LINES];
    logic [XLEN-1:0]     backing_q [MEM_WORDS];

    dc_state_e           state_q;
    logic [DC_CNT_W-1:0] cnt_q;
    logic [XLEN-3:0]     ld_waddr_q;

    logic [DC_IDX_W-1:0] ld_idx;
    logic [DC_TAG_W-1:0] ld_tag;
    logic                ld_hit;
    logic                fill_go;

    logic [XLEN-3:0]     st_waddr;
    logic [DC_IDX_W-1:0] st_idx;
    logic [DC_TAG_W-1:0] st_tag;
    logic [XLEN-1:0]     st_word;

    assign ld_idx = ld_waddr_q[DC_IDX_W-1:0];
    assign ld_tag = ld_waddr_q[XLEN-3 -: DC_TAG_W];
    assign ld_hit = valid_q[ld_idx] && (tag_q[ld_idx] == ld_tag);

    assign st_waddr = addr_i[XLEN-1:2];
    assign st_idx = st_waddr[DC_IDX_W-1:0];
    assign st_tag = st_waddr[XLEN-3 -: DC_TAG_W];

    // last fill cycle, line is written on this edge
    assign fill_go = req_i && (state_q == DC_FILL) &&
                     (cnt_q == DC_CNT_W'(DC_MISS_CYCLES - 2));

    // load sequencer, drops back to idle if the request goes away
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= DC_IDLE;
            cnt_q <= '0;
        end else if (!req_i) begin
            state_q <= DC_IDLE;
        end else begin
            case (state_q)
                DC_IDLE: begin
                    if (!we_i) begin
                        state_q <= DC_LOOKUP;
                    end
                end
                DC_LOOKUP: begin
                    if (ld_hit) begin
                        state_q <= DC_IDLE;
                    end else begin
                        state_q <= DC_FILL;
                        cnt_q <= '0;
                    end
                end
                DC_FILL: begin
                    if (fill_go) begin
                        state_q <= DC_DONE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= DC_IDLE;
                end
            endcase
        end
    end

    // load address sampled on the first edge of the request
    always_ff @(posedge clk) begin
        if (state_q == DC_IDLE) begin
            ld_waddr_q <= addr_i[XLEN-1:2];
        end
    end

    // byte merge over the current backing word
    always_comb begin
        st_word = backing_q[st_waddr[MEM_AW-1:0]];
        for (int b = 0; b < BE_W; b++) begin
            if (be_i[b]) begin
                st_word[8*b +: 8] = wdata_i[8*b +: 8];
            end
        end
    end

    // write-through with allocate on store
    always_ff @(posedge clk) begin
        if (commit_i) begin
            backing_q[st_waddr[MEM_AW-1:0]] <= st_word;
            tag_q[st_idx] <= st_tag;
            data_q[st_idx] <= st_word;
        end else if (fill_go) begin
            tag_q[ld_idx] <= ld_tag;
            data_q[ld_idx] <= backing_q[ld_waddr_q[MEM_AW-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (commit_i) begin
            valid_q[st_idx] <= 1'b1;
        end else if (fill_go) begin
            valid_q[ld_idx] <= 1'b1;
        end
    end

    assign data_ok_o = ((state_q == DC_LOOKUP) && ld_hit) || (state_q == DC_DONE);
    assign rdata_o = data_q[ld_idx];

    data_ok_needs_req_a: assert property (
        @(posedge clk) disable iff (rst_i) data_ok_o |-> req_i
    ) else $error("data_ok without a pending request");

endmodule

/* hdl/wb_stage.sv */
`timescale 1ns/10ps

module wb_stage (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       flush_i,
    input  logic                       mem_valid_i,
    input  wb_pkg::wb_op_e             mem_op_i,
    input  logic [wb_pkg::REG_AW-1:0]  mem_rd_i,
    input  logic [wb_pkg::XLEN-1:0]    mem_addr_i,
    input  logic [wb_pkg::XLEN-1:0]    mem_wdata_i,
    input  logic [wb_pkg::XLEN-1:0]    mem_result_i,
    input  logic                       mem_excp_i,
    input  logic                       dc_data_ok_i,
    input  logic [wb_pkg::XLEN-1:0]    dc_rdata_i,
    input  logic                       ll_bit_i,
    output logic                       stall_o,
    output logic                       dcache_flush_o,
    output logic                       dc_req_o,
    output logic                       dc_we_o,
    output logic [wb_pkg::BE_W-1:0]    dc_be_o,
    output logic [wb_pkg::XLEN-1:0]    dc_addr_o,
    output logic [wb_pkg::XLEN-1:0]    dc_wdata_o,
    output logic                       dc_commit_o,
    output logic                       ll_we_o,
    output logic                       ll_value_o,
    output logic                       commit_valid_o,
    output logic                       commit_we_o,
    output logic [wb_pkg::REG_AW-1:0]  commit_rd_o,
    output logic [wb_pkg::XLEN-1:0]    commit_wdata_o,
    output logic                       commit_excp_o,
    output wb_pkg::wb_op_e             commit_op_o
);

    import wb_pkg::*;

    logic            is_load;
    logic            is_st;
    logic            is_sc;
    logic            mem_store_op;
    logic            active;
    logic            accept;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [XLEN-1:0] wdata_d;

    always_comb begin
        is_load = 1'b0;
        is_st = 1'b0;
        case (mem_op_i)
            OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W, OP_LL: is_load = 1'b1;
            OP_ST_B, OP_ST_H, OP_ST_W: is_st = 1'b1;
            default: ;
        endcase
    end

    // sc only touches memory while the LL bit holds
    assign is_sc = (mem_op_i == OP_SC);
    assign mem_store_op = is_st || (is_sc && ll_bit_i);

    assign active = mem_valid_i && !mem_excp_i;
    assign stall_o = active && is_load && !dc_data_ok_i;
    assign accept = mem_valid_i && !stall_o;

    assign dcache_flush_o = mem_valid_i && mem_excp_i;
    assign dc_req_o = active && (is_load || mem_store_op);
    assign dc_we_o = mem_store_op;
    assign dc_addr_o = mem_addr_i;
    assign dc_commit_o = accept && active && mem_store_op && !flush_i;

    // sub-word stores are replicated over all lanes
    always_comb begin
        dc_be_o = 4'b1111;
        dc_wdata_o = mem_wdata_i;
        case (mem_op_i)
            OP_ST_B: begin
                dc_be_o = 4'b0001 << mem_addr_i[1:0];
                dc_wdata_o = {4{mem_wdata_i[7:0]}};
            end
            OP_ST_H: begin
                dc_be_o = mem_addr_i[1] ? 4'b1100 : 4'b0011;
                dc_wdata_o = {2{mem_wdata_i[15:0]}};
            end
            default: ;
        endcase
    end

    // load lane select and extension
    assign ld_byte = dc_rdata_i[{mem_addr_i[1:0], 3'b000} +: 8];
    assign ld_half = dc_rdata_i[{mem_addr_i[1], 4'b0000} +: 16];

    always_comb begin
        case (mem_op_i)
            OP_LD_B:        wdata_d = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            OP_LD_BU:       wdata_d = {{(XLEN-8){1'b0}}, ld_byte};
            OP_LD_H:        wdata_d = {{(XLEN-16){ld_half[15]}}, ld_half};
            OP_LD_HU:       wdata_d = {{(XLEN-16){1'b0}}, ld_half};
            OP_LD_W, OP_LL: wdata_d = dc_rdata_i;
            OP_SC:          wdata_d = {{(XLEN-1){1'b0}}, ll_bit_i};
            default:        wdata_d = mem_result_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            commit_valid_o <= 1'b0;
            ll_we_o <= 1'b0;
        end else begin
            commit_valid_o <= accept && !flush_i;
            ll_we_o <= accept && active && !flush_i && ((mem_op_i == OP_LL) || is_sc);
        end
    end

    // commit record
    always_ff @(posedge clk) begin
        if (accept) begin
            commit_we_o <= !mem_excp_i && !is_st;
            commit_rd_o <= mem_rd_i;
            commit_wdata_o <= wdata_d;
            commit_excp_o <= mem_excp_i;
            commit_op_o <= mem_op_i;
            ll_value_o <= (mem_op_i == OP_LL);
        end
    end

    excp_no_write_a: assert property (
        @(posedge clk) disable iff (rst_i) commit_valid_o |-> !(commit_we_o && commit_excp_o)
    ) else $error("excepting instruction commits a register write");

    store_no_stall_a: assert property (
        @(posedge clk) disable iff (rst_i) (mem_valid_i && (is_st || is_sc)) |-> !stall_o
    ) else $error("store stalled the stage");

endmodule

/* hdl/wb_top.sv */
`timescale 1ns/10ps

module wb_top (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       flush_i,
    input  logic                       mem_valid_i,
    input  wb_pkg::wb_op_e             mem_op_i,
    input  logic [wb_pkg::REG_AW-1:0]  mem_rd_i,
    input  logic [wb_pkg::XLEN-1:0]    mem_addr_i,
    input  logic [wb_pkg::XLEN-1:0]    mem_wdata_i,
    input  logic [wb_pkg::XLEN-1:0]    mem_result_i,
    input  logic                       mem_excp_i,
    output logic                       stall_o,
    output logic                       dcache_flush_o,
    output logic                       commit_valid_o,
    output logic                       commit_we_o,
    output logic [wb_pkg::REG_AW-1:0]  commit_rd_o,
    output logic [wb_pkg::XLEN-1:0]    commit_wdata_o,
    output logic                       commit_excp_o,
    output wb_pkg::wb_op_e             commit_op_o
);

    import wb_pkg::*;

    logic            dc_req;
    logic            dc_we;
    logic [BE_W-1:0] dc_be;
    logic [XLEN-1:0] dc_addr;
    logic [XLEN-1:0] dc_wdata;
    logic            dc_commit;
    logic            dc_data_ok;
    logic [XLEN-1:0] dc_rdata;
    logic            ll_we;
    logic            ll_value;
    logic            ll_bit;

    wb_stage wb_stage_inst (
        .clk            (clk),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .mem_valid_i    (mem_valid_i),
        .mem_op_i       (mem_op_i),
        .mem_rd_i       (mem_rd_i),
        .mem_addr_i     (mem_addr_i),
        .mem_wdata_i    (mem_wdata_i),
        .mem_result_i   (mem_result_i),
        .mem_excp_i     (mem_excp_i),
        .dc_data_ok_i   (dc_data_ok),
        .dc_rdata_i     (dc_rdata),
        .ll_bit_i       (ll_bit),
        .stall_o        (stall_o),
        .dcache_flush_o (dcache_flush_o),
        .dc_req_o       (dc_req),
        .dc_we_o        (dc_we),
        .dc_be_o        (dc_be),
        .dc_addr_o      (dc_addr),
        .dc_wdata_o     (dc_wdata),
        .dc_commit_o    (dc_commit),
        .ll_we_o        (ll_we),
        .ll_value_o     (ll_value),
        .commit_valid_o (commit_valid_o),
        .commit_we_o    (commit_we_o),
        .commit_rd_o    (commit_rd_o),
        .commit_wdata_o (commit_wdata_o),
        .commit_excp_o  (commit_excp_o),
        .commit_op_o    (commit_op_o)
    );

    dcache_lite dcache_inst (
        .clk       (clk),
        .rst_i     (rst_i),
        .req_i     (dc_req),
        .we_i      (dc_we),
        .be_i      (dc_be),
        .addr_i    (dc_addr),
        .wdata_i   (dc_wdata),
        .commit_i  (dc_commit),
        .data_ok_o (dc_data_ok),
        .rdata_o   (dc_rdata)
    );

    llbit_reg llbit_inst (
        .clk      (clk),
        .rst_i    (rst_i),
        .we_i     (ll_we),
        .value_i  (ll_value),
        .ll_bit_o (ll_bit)
    );

endmodule

/* testbench/wb_top_tb.sv */
`timescale 1ns/10ps

module wb_top_tb;

    import wb_pkg::*;

    logic              clk;
    logic              rst_i;
    logic              flush_i;
    logic              mem_valid_i;
    wb_op_e            mem_op_i;
    logic [REG_AW-1:0] mem_rd_i;
    logic [XLEN-1:0]   mem_addr_i;
    logic [XLEN-1:0]   mem_wdata_i;
    logic [XLEN-1:0]   mem_result_i;
    logic              mem_excp_i;
    logic              stall_o;
    logic              dcache_flush_o;
    logic              commit_valid_o;
    logic              commit_we_o;
    logic [REG_AW-1:0] commit_rd_o;
    logic [XLEN-1:0]   commit_wdata_o;
    logic              commit_excp_o;
    wb_op_e            commit_op_o;

    // one entry per stim line
    string       name_q[$];
    logic [31:0] op_q[$];
    logic [31:0] rd_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] wdata_q[$];
    logic [31:0] result_q[$];
    logic [31:0] excp_q[$];
    logic [31:0] flush_q[$];
    logic [31:0] exp_we_q[$];
    logic [31:0] exp_wdata_q[$];

    // accepted lines still waiting for their commit
    int expect_q[$];
    int accept_cycle_q[$];

    int mismatch_cnt = 0;
    int other_err_cnt = 0;
    int cycle_cnt = 0;
    int cycle_limit = 100000;
    int commit_idx;
    int accept_cycle;
    int line_idx;

    wb_top wb_top_inst (
        .clk            (clk),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .mem_valid_i    (mem_valid_i),
        .mem_op_i       (mem_op_i),
        .mem_rd_i       (mem_rd_i),
        .mem_addr_i     (mem_addr_i),
        .mem_wdata_i    (mem_wdata_i),
        .mem_result_i   (mem_result_i),
        .mem_excp_i     (mem_excp_i),
        .stall_o        (stall_o),
        .dcache_flush_o (dcache_flush_o),
        .commit_valid_o (commit_valid_o),
        .commit_we_o    (commit_we_o),
        .commit_rd_o    (commit_rd_o),
        .commit_wdata_o (commit_wdata_o),
        .commit_excp_o  (commit_excp_o),
        .commit_op_o    (commit_op_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            mismatch_cnt++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // load opcodes sit between LD_B and LL
    function automatic logic load_stalls(input logic [31:0] op, input logic excp);
        return (op[3:0] >= OP_LD_B) && (op[3:0] <= OP_LL) && !excp;
    endfunction

    task automatic load_stim();
        int          fd;
        int          code;
        string       col;
        string       name;
        logic [31:0] op, rd, addr, wd, res, excp, flush, we, wdata;
        fd = $fopen("testbench/wb_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/wb_stim.txt");
        end else begin
            // header line names the columns
            for (int c = 0; c < 10; c++) begin
                code = $fscanf(fd, "%s", col);
            end
            code = 10;
            while (code == 10) begin
                code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h\n",
                               name, op, rd, addr, wd, res, excp, flush, we, wdata);
                if (code == 10) begin
                    name_q.push_back(name);
                    op_q.push_back(op);
                    rd_q.push_back(rd);
                    addr_q.push_back(addr);
                    wdata_q.push_back(wd);
                    result_q.push_back(res);
                    excp_q.push_back(excp);
                    flush_q.push_back(flush);
                    exp_we_q.push_back(we);
                    exp_wdata_q.push_back(wdata);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_line(input int idx);
        logic first_stall;
        mem_valid_i <= 1'b1;
        mem_op_i <= wb_op_e'(op_q[idx][3:0]);
        mem_rd_i <= rd_q[idx][REG_AW-1:0];
        mem_addr_i <= addr_q[idx];
        mem_wdata_i <= wdata_q[idx];
        mem_result_i <= result_q[idx];
        mem_excp_i <= excp_q[idx][0];
        flush_i <= flush_q[idx][0];
        @(posedge clk);
        // a load always waits at least one cycle for the cache
        first_stall = stall_o;
        check_value({name_q[idx], " stall"},
                    {31'd0, load_stalls(op_q[idx], excp_q[idx][0])}, {31'd0, first_stall});
        // hold the line until the stall drops
        while (stall_o) begin
            @(posedge clk);
        end
        check_value({name_q[idx], " dcache_flush"}, {31'd0, excp_q[idx][0]},
                    {31'd0, dcache_flush_o});
        if (!flush_q[idx][0]) begin
            expect_q.push_back(idx);
            accept_cycle_q.push_back(cycle_cnt);
        end
    endtask

    task automatic finish_run();
        $display("Error counts: %0d mismatches, %0d other errors", mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // commit monitor
    always @(posedge clk) begin
        if (!rst_i && commit_valid_o) begin
            if (expect_q.size() == 0) begin
                $display("Commit seen with no accepted instruction waiting for it");
                other_err_cnt++;
            end else begin
                commit_idx = expect_q.pop_front();
                accept_cycle = accept_cycle_q.pop_front();
                // commit comes on the edge right after the accept edge
                check_value({name_q[commit_idx], " commit cycle"}, accept_cycle + 1,
                            cycle_cnt);
                check_value({name_q[commit_idx], " we"}, exp_we_q[commit_idx],
                            {31'd0, commit_we_o});
                check_value({name_q[commit_idx], " rd"}, rd_q[commit_idx],
                            {27'd0, commit_rd_o});
                check_value({name_q[commit_idx], " excp"}, excp_q[commit_idx],
                            {31'd0, commit_excp_o});
                check_value({name_q[commit_idx], " op"}, op_q[commit_idx],
                            {28'd0, commit_op_o});
                if (exp_we_q[commit_idx][0]) begin
                    check_value({name_q[commit_idx], " wdata"}, exp_wdata_q[commit_idx],
                                commit_wdata_o);
                end
            end
        end
    end

    initial begin
        @(posedge clk);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
        end
        $display("Run timed out after %0d cycles before all stim lines committed", cycle_cnt);
        other_err_cnt++;
        finish_run();
    end

    initial begin
        rst_i = 1'b1;
        flush_i = 1'b0;
        mem_valid_i = 1'b0;
        mem_op_i = OP_ALU;
        mem_rd_i = '0;
        mem_addr_i = '0;
        mem_wdata_i = '0;
        mem_result_i = '0;
        mem_excp_i = 1'b0;
        load_stim();
        if (name_q.size() == 0) begin
            $display("No stimulus lines could be read from the stim file");
            other_err_cnt++;
            finish_run();
        end else begin
            cycle_limit = name_q.size() * (2 + DC_MISS_CYCLES + 2) + 100;
            repeat (16) @(posedge clk);
            check_value("reset commit_valid", 32'd0, {31'd0, commit_valid_o});
            check_value("reset stall", 32'd0, {31'd0, stall_o});
            check_value("reset dcache_flush", 32'd0, {31'd0, dcache_flush_o});
            rst_i <= 1'b0;
            for (line_idx = 0; line_idx < name_q.size(); line_idx++) begin
                drive_line(line_idx);
            end
            mem_valid_i <= 1'b0;
            mem_excp_i <= 1'b0;
            flush_i <= 1'b0;
            while (expect_q.size() != 0) begin
                @(posedge clk);
            end
            // catch stray commits
            repeat (3) @(posedge clk);
            finish_run();
        end
    end

endmodule

/* testbench/wb_stim.txt */
name op rd addr wdata result excp flush exp_we exp_wdata
alu_a 0 01 00000000 00000000 12345678 0 0 1 12345678
alu_b 0 1f 00000000 00000000 deadbeef 0 0 1 deadbeef
st_w 9 00 00000100 80f17f22 00000000 0 0 0 00000000
ld_w 5 02 00000100 00000000 00000000 0 0 1 80f17f22
ld_b_neg 1 03 00000103 00000000 00000000 0 0 1 ffffff80
ld_bu 2 04 00000103 00000000 00000000 0 0 1 00000080
ld_h_neg 3 05 00000102 00000000 00000000 0 0 1 ffff80f1
ld_hu 4 06 00000102 00000000 00000000 0 0 1 000080f1
ld_b_pos 1 07 00000101 00000000 00000000 0 0 1 0000007f
st_b 7 00 00000101 000000aa 00000000 0 0 0 00000000
ld_w_st_b 5 08 00000100 00000000 00000000 0 0 1 80f1aa22
st_h 8 00 00000102 00005566 00000000 0 0 0 00000000
ld_w_st_h 5 09 00000100 00000000 00000000 0 0 1 5566aa22
ld_h_low 3 0a 00000100 00000000 00000000 0 0 1 ffffaa22
st_w_evict 9 00 00000200 0badf00d 00000000 0 0 0 00000000
ld_w_miss 5 0b 00000100 00000000 00000000 0 0 1 5566aa22
ld_w_hit 5 0c 00000100 00000000 00000000 0 0 1 5566aa22
ld_w_miss2 5 0d 00000200 00000000 00000000 0 0 1 0badf00d
st_w_ll 9 00 00000144 11111111 00000000 0 0 0 00000000
ll 6 0e 00000144 00000000 00000000 0 0 1 11111111
sc_ok a 0f 00000144 22222222 00000000 0 0 1 00000001
ld_w_sc 5 10 00000144 00000000 00000000 0 0 1 22222222
sc_fail a 11 00000144 33333333 00000000 0 0 1 00000000
ld_w_sc_fail 5 12 00000144 00000000 00000000 0 0 1 22222222
st_w_excp 9 00 00000144 44444444 00000000 1 0 0 00000000
ld_w_excp 5 13 00000144 00000000 00000000 0 0 1 22222222
alu_flush 0 14 00000000 00000000 99999999 0 1 0 00000000
st_w_flush 9 00 00000144 55555555 00000000 0 1 0 00000000
alu_after 0 15 00000000 00000000 0000abcd 0 0 1 0000abcd
ld_w_flush 5 16 00000144 00000000 00000000 0 0 1 22222222

/* wb_subsys.f */
common/wb_pkg.sv
hdl/llbit_reg.sv
dcache/dcache_lite.sv
hdl/wb_stage.sv
hdl/wb_top.sv
testbench/wb_top_tb.sv

/* Makefile */
TOP := wb_top_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f wb_subsys.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f wb_subsys.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
